// ==== hw/tetris_settings.svh ====
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

// ================================================
// play field
// ================================================
`define BOARD_COLS  10
`define BOARD_ROWS  24          // hidden rows included
`define HIDDEN_ROWS 4           // top rows, above the visible field

`define SPAWN_X 3               // top-left corner of the 4x4 box
`define SPAWN_Y 0

// ================================================
// timing, score and piece generator
// ================================================
`define DROP_PERIOD 16          // cycles per gravity step
`define SCORE_W     10
`define CUR_SEED    5'b01011
`define NEXT_SEED   5'b11101

`endif

// ==== hw/tetris_pkg.sv ====
`include "tetris_settings.svh"

package tetris_pkg;

	// ================================================
	// enums
	// ================================================
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SPAWN,
		ST_FALL,
		ST_PLACE,
		ST_CLEAR,
		ST_OVER
	} game_state_e;

	typedef enum logic [2:0] {
		CMD_START,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_ROT_CCW,
		CMD_ROT_CW,
		CMD_DOWN
	} move_cmd_e;

	typedef enum logic [2:0] {
		SHAPE_O,
		SHAPE_I,
		SHAPE_S,
		SHAPE_Z,
		SHAPE_L,
		SHAPE_J,
		SHAPE_T
	} shape_e;

	typedef logic [1:0]               rot_t;    // ccw +1, cw -1
	typedef logic signed [5:0]        pos_t;
	typedef logic [`BOARD_COLS-1:0]   row_t;    // bit c is column c
	typedef row_t [`BOARD_ROWS-1:0]   board_t;  // row 0 on top
	typedef logic [15:0]              mask_t;   // bit 4*r+c is box row r, col c
	typedef logic [`SCORE_W-1:0]      score_t;

	// ================================================
	// shape table
	// ================================================
	function automatic mask_t shape_mask(shape_e shape, rot_t rot);
		mask_t m;
		case (shape)
			SHAPE_O: m = 16'h0033;
			SHAPE_I: m = rot[0] ? 16'h1111 : 16'h000f;
			SHAPE_S: m = rot[0] ? 16'h0231 : 16'h0036;
			SHAPE_Z: m = rot[0] ? 16'h0132 : 16'h0063;
			SHAPE_L: begin
				case (rot)
					2'd0:    m = 16'h0074;
					2'd1:    m = 16'h0223;
					2'd2:    m = 16'h0017;
					default: m = 16'h0311;
				endcase
			end
			SHAPE_J: begin
				case (rot)
					2'd0:    m = 16'h0071;
					2'd1:    m = 16'h0322;
					2'd2:    m = 16'h0047;
					default: m = 16'h0113;
				endcase
			end
			default: begin // T and the unused code
				case (rot)
					2'd0:    m = 16'h0027;
					2'd1:    m = 16'h0131;
					2'd2:    m = 16'h0072;
					default: m = 16'h0232;
				endcase
			end
		endcase
		return m;
	endfunction

endpackage

// ==== hw/drop_timer.sv ====
`timescale 1ns/1ps
`include "tetris_settings.svh"

module drop_timer (
	input  logic clk,
	input  logic rst,
	input  logic timer_run,
	output logic drop_tick
);
	localparam int CNT_W = $clog2(`DROP_PERIOD + 1);

	logic [CNT_W-1:0] cnt;

	assign drop_tick = timer_run && (cnt == CNT_W'(`DROP_PERIOD - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
		end else if (!timer_run || drop_tick) begin
			cnt <= '0; // restart on entry and after each step
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// ticks come one gravity period apart
	a_tick_gap: assert property (@(posedge clk) disable iff (!rst)
		drop_tick |=> !drop_tick [*(`DROP_PERIOD - 1)]);

endmodule

// ==== hw/piece_gen.sv ====
`timescale 1ns/1ps
`include "tetris_settings.svh"

module piece_gen (
	input  logic               clk,
	input  logic               rst,
	input  logic               spawn,
	output tetris_pkg::shape_e cur_shape,
	output tetris_pkg::shape_e next_shape
);
	import tetris_pkg::*;

	localparam logic [4:0] CUR_INIT = `CUR_SEED;

	logic [4:0] lfsr;
	logic [4:0] lfsr_nxt;

	function automatic shape_e to_shape(logic [2:0] v);
		return (v == 3'd7) ? SHAPE_T : shape_e'(v); // 7 folds onto T
	endfunction

	assign lfsr_nxt   = {lfsr[2] ^ lfsr[3], lfsr[0] ^ lfsr[4], lfsr[3] ^ lfsr[4], lfsr[2], lfsr[1]};
	assign next_shape = to_shape(lfsr[2:0]); // preview

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			lfsr      <= `NEXT_SEED;
			cur_shape <= to_shape(CUR_INIT[2:0]);
		end else if (spawn) begin
			lfsr      <= lfsr_nxt;
			cur_shape <= next_shape;
		end
	end

endmodule

// ==== hw/collision_check.sv ====
`timescale 1ns/1ps
`include "tetris_settings.svh"

module collision_check (
	input  tetris_pkg::shape_e shape,
	input  tetris_pkg::pos_t   probe_x,
	input  tetris_pkg::pos_t   probe_y,
	input  tetris_pkg::rot_t   probe_rot,
	input  tetris_pkg::board_t board,
	output logic               hit
);
	import tetris_pkg::*;

	mask_t mask;

	assign mask = shape_mask(shape, probe_rot);

	always_comb begin : cell_scan
		int cx;
		int cy;
		hit = 1'b0;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				cx = int'(probe_x) + c;
				cy = int'(probe_y) + r;
				if (mask[4*r+c]) begin
					if (cx < 0 || cx >= `BOARD_COLS || cy >= `BOARD_ROWS) begin
						hit = 1'b1; // wall or floor
					end else if (cy >= 0 && board[cy][cx]) begin
						hit = 1'b1; // stack
					end
				end
			end
		end
	end

endmodule

// ==== hw/board_store.sv ====
`timescale 1ns/1ps
`include "tetris_settings.svh"

module board_store (
	input  logic               clk,
	input  logic               rst,
	input  tetris_pkg::shape_e shape,
	input  tetris_pkg::pos_t   piece_x,
	input  tetris_pkg::pos_t   piece_y,
	input  tetris_pkg::rot_t   piece_rot,
	input  logic               place,
	input  logic               clear_start,
	output logic               clear_done,
	output logic               overflow,
	output tetris_pkg::board_t board,
	output tetris_pkg::score_t score
);
	import tetris_pkg::*;

	localparam int ROW_W = $clog2(`BOARD_ROWS);

	typedef logic signed [ROW_W:0] wr_t;

	mask_t            mask;
	board_t           cells;     // piece cells at board position
	board_t           board_nxt;
	logic             busy;
	logic [ROW_W-1:0] rd_row;
	wr_t              wr_row;
	wr_t              wr_nxt;
	logic             row_full;

	assign mask       = shape_mask(shape, piece_rot);
	assign row_full   = &board[rd_row];
	assign wr_nxt     = row_full ? wr_row : wr_row - wr_t'(1);
	assign clear_done = busy && (rd_row == '0);
	// taken from the next board so the last scan cycle already shows the result
	assign overflow   = |board_nxt[`HIDDEN_ROWS-1:0];

	always_comb begin : overlay
		int cx;
		int cy;
		cells = '0;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				cx = int'(piece_x) + c;
				cy = int'(piece_y) + r;
				if (mask[4*r+c] && cx >= 0 && cx < `BOARD_COLS && cy >= 0 && cy < `BOARD_ROWS) begin
					cells[cy][cx] = 1'b1;
				end
			end
		end
	end

	// ================================================
	// placement and row compaction
	// ================================================
	always_comb begin
		board_nxt = board;
		if (place) begin
			board_nxt = board | cells;
		end else if (busy) begin
			if (!row_full) begin
				board_nxt[wr_row[ROW_W-1:0]] = board[rd_row]; // wr_row >= rd_row here
			end
			if (rd_row == '0) begin
				for (int i = 0; i < `BOARD_ROWS; i++) begin
					if (i <= wr_nxt) board_nxt[i] = '0; // freed rows at the top
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			board  <= '0;
			score  <= '0;
			busy   <= 1'b0;
			rd_row <= '0;
			wr_row <= '0;
		end else begin
			board <= board_nxt;
			if (clear_start) begin
				busy   <= 1'b1;
				rd_row <= ROW_W'(`BOARD_ROWS - 1);
				wr_row <= wr_t'(`BOARD_ROWS - 1);
			end else if (busy) begin
				rd_row <= rd_row - 1'b1;
				wr_row <= wr_nxt;
				if (row_full) score <= score + 1'b1;
				if (rd_row == '0) busy <= 1'b0;
			end
		end
	end

	a_place_free: assert property (@(posedge clk) disable iff (!rst)
		place |-> ((board & cells) == '0));

endmodule

// ==== hw/game_ctrl.sv ====
`timescale 1ns/1ps
`include "tetris_settings.svh"

module game_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cmd_valid,
	input  tetris_pkg::move_cmd_e cmd,
	output logic                  cmd_ready,
	input  logic                  drop_tick,
	output logic                  timer_run,
	input  logic                  hit,
	input  logic                  overflow,
	input  logic                  clear_done,
	output tetris_pkg::pos_t      probe_x,
	output tetris_pkg::pos_t      probe_y,
	output tetris_pkg::rot_t      probe_rot,
	output tetris_pkg::pos_t      piece_x,
	output tetris_pkg::pos_t      piece_y,
	output tetris_pkg::rot_t      piece_rot,
	output logic                  spawn,
	output logic                  place,
	output logic                  clear_start,
	output logic                  playing,
	output logic                  game_over
);
	import tetris_pkg::*;

	game_state_e state;
	game_state_e state_nxt;
	logic        accept;
	logic        move;  // command taken while falling
	logic        step;  // gravity or soft drop

	assign cmd_ready   = (state == ST_IDLE) || (state == ST_FALL && !drop_tick);
	assign accept      = cmd_valid && cmd_ready;
	assign move        = accept && (state == ST_FALL);
	assign step        = drop_tick || (move && cmd == CMD_DOWN);
	assign timer_run   = (state == ST_FALL);
	assign spawn       = (state == ST_SPAWN);
	assign place       = (state == ST_PLACE);
	assign clear_start = (state == ST_PLACE); // scan begins once the piece is written
	assign playing     = state inside {ST_SPAWN, ST_FALL, ST_PLACE, ST_CLEAR};
	assign game_over   = (state == ST_OVER);

	// ================================================
	// candidate placement
	// ================================================
	always_comb begin
		probe_x   = piece_x;
		probe_y   = piece_y;
		probe_rot = piece_rot;
		if (drop_tick) begin
			probe_y = piece_y + pos_t'(1);
		end else if (move) begin
			case (cmd)
				CMD_LEFT:    probe_x   = piece_x - pos_t'(1);
				CMD_RIGHT:   probe_x   = piece_x + pos_t'(1);
				CMD_ROT_CCW: probe_rot = piece_rot + 2'd1;
				CMD_ROT_CW:  probe_rot = piece_rot - 2'd1;
				CMD_DOWN:    probe_y   = piece_y + pos_t'(1);
				default:     probe_x   = piece_x; // start while falling does nothing
			endcase
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:  if (accept && cmd == CMD_START) state_nxt = ST_SPAWN;
			ST_SPAWN: state_nxt = ST_FALL;
			ST_FALL:  if (step && hit) state_nxt = ST_PLACE; // landed
			ST_PLACE: state_nxt = ST_CLEAR;
			ST_CLEAR: if (clear_done) state_nxt = overflow ? ST_OVER : ST_SPAWN;
			ST_OVER:  state_nxt = ST_OVER;
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= ST_IDLE;
			piece_x   <= pos_t'(`SPAWN_X);
			piece_y   <= pos_t'(`SPAWN_Y);
			piece_rot <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_SPAWN) begin
				piece_x   <= pos_t'(`SPAWN_X);
				piece_y   <= pos_t'(`SPAWN_Y);
				piece_rot <= '0;
			end else if ((drop_tick || move) && !hit) begin
				piece_x   <= probe_x;
				piece_y   <= probe_y;
				piece_rot <= probe_rot;
			end
		end
	end

	// the board scan holds the FSM for one cycle per row
	a_clear_len: assert property (@(posedge clk) disable iff (!rst)
		(state == ST_PLACE) |=> (state == ST_CLEAR) [*`BOARD_ROWS] ##1 (state != ST_CLEAR));

endmodule

// ==== hw/tetris_core.sv ====
`timescale 1ns/1ps

module tetris_core (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cmd_valid,
	input  tetris_pkg::move_cmd_e cmd,
	output logic                  cmd_ready,
	output tetris_pkg::board_t    board,
	output tetris_pkg::shape_e    piece_shape,
	output tetris_pkg::shape_e    next_shape,
	output tetris_pkg::pos_t      piece_x,
	output tetris_pkg::pos_t      piece_y,
	output tetris_pkg::rot_t      piece_rot,
	output logic                  playing,
	output logic                  game_over,
	output tetris_pkg::score_t    score
);
	import tetris_pkg::*;

	logic drop_tick;
	logic timer_run;
	logic hit;
	logic overflow;
	logic clear_done;
	logic spawn;
	logic place;
	logic clear_start;
	pos_t probe_x;
	pos_t probe_y;
	rot_t probe_rot;

	// ================================================
	// control
	// ================================================
	game_ctrl i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.drop_tick   (drop_tick),
		.timer_run   (timer_run),
		.hit         (hit),
		.overflow    (overflow),
		.clear_done  (clear_done),
		.probe_x     (probe_x),
		.probe_y     (probe_y),
		.probe_rot   (probe_rot),
		.piece_x     (piece_x),
		.piece_y     (piece_y),
		.piece_rot   (piece_rot),
		.spawn       (spawn),
		.place       (place),
		.clear_start (clear_start),
		.playing     (playing),
		.game_over   (game_over)
	);

	// ================================================
	// datapath
	// ================================================
	collision_check i_coll (
		.shape     (piece_shape),
		.probe_x   (probe_x),
		.probe_y   (probe_y),
		.probe_rot (probe_rot),
		.board     (board),
		.hit       (hit)
	);

	board_store i_board (
		.clk         (clk),
		.rst         (rst),
		.shape       (piece_shape),
		.piece_x     (piece_x),
		.piece_y     (piece_y),
		.piece_rot   (piece_rot),
		.place       (place),
		.clear_start (clear_start),
		.clear_done  (clear_done),
		.overflow    (overflow),
		.board       (board),
		.score       (score)
	);

	piece_gen i_gen (
		.clk        (clk),
		.rst        (rst),
		.spawn      (spawn),
		.cur_shape  (piece_shape),
		.next_shape (next_shape)
	);

	drop_timer i_timer (
		.clk       (clk),
		.rst       (rst),
		.timer_run (timer_run),
		.drop_tick (drop_tick)
	);

endmodule

// ==== verification/tb_tetris.sv ====
`timescale 1ns/1ps
`include "tetris_settings.svh"

module tb_tetris;
	import tetris_pkg::*;

	localparam int SEED         = 94674;
	localparam int GAMES        = 8;
	localparam int CMD_TIMEOUT  = 200;
	localparam int FALL_TIMEOUT = 200;
	localparam int DROP_LIMIT   = 64;
	localparam int MAX_PIECES   = 3000;

	logic        clk;
	logic        rst;
	logic        cmd_valid;
	move_cmd_e   cmd;
	logic        cmd_ready;
	board_t      board;
	shape_e      piece_shape;
	shape_e      next_shape;
	pos_t        piece_x;
	pos_t        piece_y;
	rot_t        piece_rot;
	logic        playing;
	logic        game_over;
	score_t      score;

	game_state_e st;
	game_state_e prev_st;
	logic        accept;
	logic        model_tick;
	int          fall_cycles;
	logic        prev_accept;
	logic        prev_tick;
	move_cmd_e   prev_cmd;
	pos_t        prev_x;
	pos_t        prev_y;
	rot_t        prev_rot;
	shape_e      prev_next;
	board_t      prev_board;
	score_t      prev_score;
	pos_t        x_moved;
	rot_t        rot_moved;
	logic        have_last;
	int          last_cells;
	int          last_score;
	int          spawns;
	logic        clear_seen;

	tetris_core i_dut (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.board       (board),
		.piece_shape (piece_shape),
		.next_shape  (next_shape),
		.piece_x     (piece_x),
		.piece_y     (piece_y),
		.piece_rot   (piece_rot),
		.playing     (playing),
		.game_over   (game_over),
		.score       (score)
	);

	always #4 clk = ~clk;

	assign st         = i_dut.i_ctrl.state;
	assign accept     = cmd_valid && cmd_ready;
	// gravity on every DROP_PERIOD-th falling cycle
	assign model_tick = (st == ST_FALL) && ((fall_cycles + 1) % `DROP_PERIOD == 0);
	assign x_moved    = (prev_cmd == CMD_RIGHT) ? prev_x + pos_t'(1) : prev_x - pos_t'(1);
	assign rot_moved  = (prev_cmd == CMD_ROT_CCW) ? prev_rot + 2'd1 : prev_rot - 2'd1;

	// ================================================
	// reference model helpers
	// ================================================
	function automatic bit fits(shape_e s, pos_t x, pos_t y, rot_t r, board_t b);
		mask_t m;
		int    cx;
		int    cy;
		m = shape_mask(s, r);
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				cx = int'(x) + j;
				cy = int'(y) + i;
				if (m[4*i+j]) begin
					if (cx < 0 || cx >= `BOARD_COLS || cy < 0 || cy >= `BOARD_ROWS) return 1'b0;
					if (b[cy][cx]) return 1'b0;
				end
			end
		end
		return 1'b1;
	endfunction

	function automatic int land_row(shape_e s, rot_t r, int x, board_t b);
		int y;
		y = -1; // stays -1 if blocked at the top
		while (y < `BOARD_ROWS && fits(s, pos_t'(x), pos_t'(y + 1), r, b)) y++;
		return y;
	endfunction

	function automatic int count_cells(board_t b);
		int n;
		n = 0;
		for (int i = 0; i < `BOARD_ROWS; i++) n += $countones(b[i]);
		return n;
	endfunction

	function automatic bit has_full_row(board_t b);
		for (int i = 0; i < `BOARD_ROWS; i++) begin
			if (&b[i]) return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		stop_with_failure($sformatf("FAIL t=%0t %s expected %0h got %0h",
			$time, name, expected, actual));
	endtask

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			prev_st     <= ST_IDLE;
			prev_accept <= 1'b0;
			prev_tick   <= 1'b0;
			prev_cmd    <= CMD_START;
			prev_x      <= '0;
			prev_y      <= '0;
			prev_rot    <= '0;
			prev_next   <= SHAPE_O;
			prev_board  <= '0;
			prev_score  <= '0;
			fall_cycles <= 0;
			have_last   <= 1'b0;
			last_cells  <= 0;
			last_score  <= 0;
			spawns      <= 0;
		end else begin
			prev_st     <= st;
			prev_accept <= accept;
			prev_tick   <= model_tick;
			prev_cmd    <= cmd;
			prev_x      <= piece_x;
			prev_y      <= piece_y;
			prev_rot    <= piece_rot;
			prev_next   <= next_shape;
			prev_board  <= board;
			prev_score  <= score;
			fall_cycles <= (st == ST_FALL) ? fall_cycles + 1 : 0;
			if (st == ST_SPAWN) begin
				have_last  <= 1'b1;
				last_cells <= count_cells(board);
				last_score <= int'(score);
				spawns     <= spawns + 1;
			end
		end
	end

	// ================================================
	// checks
	// ================================================
	a_idle_flags: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_IDLE) |-> ({playing, game_over, cmd_ready} == 3'b001))
		else report_mismatch("{playing,game_over,cmd_ready}", 3'b001,
			$sampled({playing, game_over, cmd_ready}));
	a_idle_score: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_IDLE) |-> (score == '0))
		else report_mismatch("score", 0, $sampled(score));
	a_idle_board: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_IDLE) |-> (board == '0))
		else report_mismatch("board", 0, $sampled(board));

	a_play_flag: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_FALL) |-> ({playing, game_over} == 2'b10))
		else report_mismatch("{playing,game_over}", 2'b10, $sampled({playing, game_over}));

	a_spawn_pos: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_SPAWN) |->
		({piece_x, piece_y, piece_rot} == {pos_t'(`SPAWN_X), pos_t'(`SPAWN_Y), 2'd0}))
		else report_mismatch("{piece_x,piece_y,piece_rot}",
			{pos_t'(`SPAWN_X), pos_t'(`SPAWN_Y), 2'd0}, $sampled({piece_x, piece_y, piece_rot}));
	a_spawn_shape: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_SPAWN) |-> (piece_shape == prev_next))
		else report_mismatch("piece_shape", $sampled(prev_next), $sampled(piece_shape));

	a_fit: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_FALL) |-> fits(piece_shape, piece_x, piece_y, piece_rot, board))
		else stop_with_failure("falling piece lies outside the field or on the stack");
	a_move_x: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_FALL && prev_accept && prev_cmd inside {CMD_LEFT, CMD_RIGHT}) |->
		(piece_x == prev_x || piece_x == x_moved))
		else report_mismatch("piece_x", $sampled({x_moved}), $sampled({piece_x}));
	a_move_rot: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_FALL && prev_accept && prev_cmd inside {CMD_ROT_CCW, CMD_ROT_CW}) |->
		(piece_rot == prev_rot || piece_rot == rot_moved))
		else report_mismatch("piece_rot", $sampled(rot_moved), $sampled(piece_rot));

	a_gravity: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_FALL && prev_tick) |-> (piece_y == prev_y + pos_t'(1) || st == ST_PLACE))
		else report_mismatch("piece_y", $sampled({pos_t'(prev_y + pos_t'(1))}),
			$sampled({piece_y}));
	a_hold: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_FALL && !prev_tick && !prev_accept) |-> (piece_y == prev_y))
		else report_mismatch("piece_y", $sampled({prev_y}), $sampled({piece_y}));

	a_cells: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_SPAWN && have_last) |->
		(count_cells(board) == last_cells + 4 - `BOARD_COLS * (int'(score) - last_score)))
		else report_mismatch("occupied cells",
			$sampled(last_cells + 4 - `BOARD_COLS * (int'(score) - last_score)),
			$sampled(count_cells(board)));
	a_no_full: assert property (@(posedge clk) disable iff (!rst)
		(st == ST_SPAWN) |-> !has_full_row(board))
		else stop_with_failure("a full row is left on the board after clearing");

	a_over_ready: assert property (@(posedge clk) disable iff (!rst)
		game_over |-> !cmd_ready)
		else report_mismatch("cmd_ready", 0, $sampled(cmd_ready));
	a_over_board: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_OVER) |-> (board == prev_board && game_over))
		else report_mismatch("board", $sampled(prev_board), $sampled(board));
	a_over_score: assert property (@(posedge clk) disable iff (!rst)
		(prev_st == ST_OVER) |-> (score == prev_score))
		else report_mismatch("score", $sampled(prev_score), $sampled(score));

	// ================================================
	// stimulus
	// ================================================
	task automatic apply_reset();
		cmd_valid = 1'b0;
		rst       = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
	endtask

	task automatic send_cmd(input move_cmd_e c);
		int   waited;
		logic taken;
		waited = 0;
		taken  = 1'b0;
		repeat ($urandom % 3) begin
			@(posedge clk);
			#1;
		end
		cmd_valid = 1'b1;
		cmd       = c;
		while (!taken && !game_over) begin
			taken = cmd_ready; // stable until the next edge
			@(posedge clk);
			#1;
			waited++;
			if (waited > CMD_TIMEOUT) stop_with_failure("command was not accepted in time");
		end
		cmd_valid = 1'b0;
	endtask

	task automatic wait_fall();
		int waited;
		waited = 0;
		while (st != ST_FALL && !game_over) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > FALL_TIMEOUT) stop_with_failure("no piece started to fall in time");
		end
	endtask

	task automatic play_piece();
		int   best_row;
		int   best_x;
		int   row;
		int   dx;
		int   drops;
		int   start_count;
		int   cw_steps;
		rot_t best_rot;
		best_row = -2;
		best_x   = `SPAWN_X;
		best_rot = '0;
		for (int r = 0; r < 4; r++) begin
			for (int x = -3; x < `BOARD_COLS; x++) begin
				row = land_row(piece_shape, rot_t'(r), x, board);
				if (row > best_row || (row == best_row && $urandom % 2 == 1)) begin
					best_row = row;
					best_x   = x;
					best_rot = rot_t'(r);
				end
			end
		end
		if ($urandom % 2 == 1) begin // random target half the time
			best_rot = rot_t'($urandom % 4);
			best_x   = int'($urandom % 13) - 3;
		end
		cw_steps = (4 - int'(best_rot)) % 4;
		if ($urandom % 2 == 1) begin // either way round
			repeat (cw_steps) send_cmd(CMD_ROT_CW);
		end else begin
			repeat (best_rot) send_cmd(CMD_ROT_CCW);
		end
		dx = best_x - int'(piece_x);
		while (dx < 0 && !game_over) begin
			send_cmd(CMD_LEFT);
			dx++;
		end
		while (dx > 0 && !game_over) begin
			send_cmd(CMD_RIGHT);
			dx--;
		end
		start_count = spawns;
		drops       = 0;
		while (spawns == start_count && !game_over) begin
			send_cmd(CMD_DOWN);
			drops++;
			if (drops > DROP_LIMIT) stop_with_failure("piece did not land");
		end
	endtask

	initial begin : stimulus
		int pieces;
		clk        = 1'b0;
		rst        = 1'b0;
		cmd_valid  = 1'b0;
		cmd        = CMD_START;
		clear_seen = 1'b0;
		void'($urandom(SEED));
		for (int game = 0; game < GAMES; game++) begin
			apply_reset();
			send_cmd(move_cmd_e'(1 + $urandom % 5)); // no effect while idle
			send_cmd(CMD_START);
			pieces = 0;
			while (!game_over) begin
				wait_fall();
				if (!game_over) play_piece();
				pieces++;
				if (pieces > MAX_PIECES) stop_with_failure("game did not end");
			end
			cmd_valid = 1'b1; // pressure the stopped game
			cmd       = move_cmd_e'(1 + $urandom % 5);
			repeat (20) begin
				@(posedge clk);
				#1;
			end
			cmd_valid = 1'b0;
			if (score != '0) clear_seen = 1'b1;
		end
		if (clear_seen) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_with_failure("no row was cleared in any game");
		end
	end

endmodule

// ==== build.f ====
+incdir+hw
hw/tetris_pkg.sv
hw/drop_timer.sv
hw/piece_gen.sv
hw/collision_check.sv
hw/board_store.sv
hw/game_ctrl.sv
hw/tetris_core.sv
verification/tb_tetris.sv

// ==== Bender.yml ====
package:
  name: tetris_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/tetris_pkg.sv
      - hw/drop_timer.sv
      - hw/piece_gen.sv
      - hw/collision_check.sv
      - hw/board_store.sv
      - hw/game_ctrl.sv
      - hw/tetris_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_tetris.sv
